// File: design/bmc_pkg.sv
`default_nettype none

package bmc_pkg;

  localparam int bus_addr_w = 16;
  localparam int bus_data_w = 16;

  // host request, held steady until ack or err comes back
  typedef struct packed {
    logic                  cyc;
    logic                  stb;
    logic                  we;
    logic [bus_addr_w-1:0] adr;
    logic [bus_data_w-1:0] dat;
  } bus_req_t;

  typedef struct packed {
    logic                  ack;
    logic                  err;
    logic [bus_data_w-1:0] dat;  // read data, valid with ack
  } bus_rsp_t;

  localparam int num_slaves  = 3;
  localparam int slv_sysconf = 0;
  localparam int slv_pwrman  = 1;
  localparam int slv_irqc    = 2;

  // memory map, inclusive ranges
  localparam logic [bus_addr_w-1:0] sysconf_base = 16'h0000;
  localparam logic [bus_addr_w-1:0] sysconf_high = 16'h000F;
  localparam logic [bus_addr_w-1:0] pwrman_base  = 16'h0010;
  localparam logic [bus_addr_w-1:0] pwrman_high  = 16'h001F;
  localparam logic [bus_addr_w-1:0] irqc_base    = 16'h0020;
  localparam logic [bus_addr_w-1:0] irqc_high    = 16'h002F;

  // register offsets within a slave, low address nibble
  localparam logic [3:0] reg_board_id   = 4'h0;  // board id high byte, major rev low byte
  localparam logic [3:0] reg_rev_minor  = 4'h1;
  localparam logic [3:0] reg_config     = 4'h2;
  localparam logic [3:0] reg_pwr_ctrl   = 4'h0;  // bit 0 power request
  localparam logic [3:0] reg_pwr_status = 4'h1;
  localparam logic [3:0] reg_irq_status = 4'h0;  // write 1 to clear
  localparam logic [3:0] reg_irq_mask   = 4'h1;

  typedef struct packed {
    logic       track_2v5;
    logic [4:0] inhibit;  // 2v5, 1v8, 1v5, 1v2, 1v0
    logic [2:0] mgt_en;   // avcc, avttx, avccpll
  } rail_ctrl_t;

  typedef struct packed {
    logic [2:0] mgt_pg;
    logic       aux_3v3_pg;
  } rail_pg_t;

  typedef enum logic [2:0] {
    pwr_off        = 3'd0,
    pwr_wait_atx   = 3'd1,
    pwr_wait_rails = 3'd2,
    pwr_on         = 3'd3,
    pwr_down_wait  = 3'd4
  } pwr_state_e;

  // why the board last went to pwr_off
  typedef enum logic [1:0] {
    cause_none      = 2'd0,
    cause_host_off  = 2'd1,
    cause_atx_fault = 2'd2,
    cause_button    = 2'd3
  } pwr_cause_e;

  localparam int num_irq        = 3;
  localparam int irq_bit_button = 0;
  localparam int irq_bit_memv   = 1;
  localparam int irq_bit_fault  = 2;

endpackage

`default_nettype wire

// File: design/bmc_top.sv
`default_nettype none

module bmc_top import bmc_pkg::*; #(
  parameter logic [7:0]  BOARD_ID         = 8'h42,
  parameter logic [7:0]  REV_MAJOR        = 8'h01,
  parameter logic [15:0] REV_MINOR        = 16'h0003,
  parameter int          DEBOUNCE_CYCLES  = 32'h0020_0000,
  parameter int          POWER_UP_TIMEOUT = 40_000_000,
  parameter int          POWER_DOWN_WAIT  = 200_000_000,
  parameter int          BLINK_BIT        = 24
) (
  input  wire             gclk40,
  input  wire             hard_reset,
  input  wire bus_req_t   host_req_i,
  output bus_rsp_t        host_rsp_o,
  input  wire             chs_powerdown_n_i,
  input  wire             atx_pwr_ok_i,
  output logic            atx_ps_on_n_o,
  output logic            atx_load_res_off_o,
  output rail_ctrl_t      rail_ctrl_o,
  input  wire rail_pg_t   rail_pg_i,
  output logic [7:0]      sys_config_o,
  output logic            controller_irq_o,
  output logic            controller_reset_o,
  output logic [1:0]      chs_led_n_o
);

  logic [num_slaves-1:0] slave_sel;
  bus_rsp_t              slave_rsp [num_slaves];
  logic                  memv;
  logic                  button_pressed;
  logic                  power_ok;
  pwr_cause_e            pwr_cause;
  logic                  pwr_pending;
  logic                  pwr_fault;
  logic [num_irq-1:0]    irq_src;

  assign irq_src[irq_bit_button] = pwr_pending;
  assign irq_src[irq_bit_memv]   = memv;
  assign irq_src[irq_bit_fault]  = pwr_fault;

  button_debouncer #(
    .DEBOUNCE_CYCLES(DEBOUNCE_CYCLES)
  ) button_debouncer_inst (
    .gclk40(gclk40), .hard_reset(hard_reset),
    .button_n_i(chs_powerdown_n_i), .pressed_o(button_pressed)
  );

  bus_decoder bus_decoder_inst (
    .gclk40(gclk40), .hard_reset(hard_reset),
    .host_req_i(host_req_i), .host_rsp_o(host_rsp_o),
    .slave_sel_o(slave_sel), .slave_rsp_i(slave_rsp),
    .memv_o(memv)
  );

  sys_config_regs #(
    .BOARD_ID(BOARD_ID), .REV_MAJOR(REV_MAJOR), .REV_MINOR(REV_MINOR)
  ) sys_config_regs_inst (
    .gclk40(gclk40), .hard_reset(hard_reset),
    .sel_i(slave_sel[slv_sysconf]), .req_i(host_req_i), .rsp_o(slave_rsp[slv_sysconf]),
    .sys_config_o(sys_config_o)
  );

  power_sequencer #(
    .POWER_UP_TIMEOUT(POWER_UP_TIMEOUT), .POWER_DOWN_WAIT(POWER_DOWN_WAIT)
  ) power_sequencer_inst (
    .gclk40(gclk40), .hard_reset(hard_reset),
    .sel_i(slave_sel[slv_pwrman]), .req_i(host_req_i), .rsp_o(slave_rsp[slv_pwrman]),
    .button_i(button_pressed), .atx_pwr_ok_i(atx_pwr_ok_i), .rail_pg_i(rail_pg_i),
    .atx_ps_on_n_o(atx_ps_on_n_o), .atx_load_res_off_o(atx_load_res_off_o),
    .rail_ctrl_o(rail_ctrl_o), .power_ok_o(power_ok), .cause_o(pwr_cause),
    .pending_o(pwr_pending), .fault_o(pwr_fault)
  );

  irq_controller irq_controller_inst (
    .gclk40(gclk40), .hard_reset(hard_reset),
    .sel_i(slave_sel[slv_irqc]), .req_i(host_req_i), .rsp_o(slave_rsp[slv_irqc]),
    .irq_src_i(irq_src), .irq_o(controller_irq_o)
  );

  chassis_led #(
    .BLINK_BIT(BLINK_BIT)
  ) chassis_led_inst (
    .gclk40(gclk40), .hard_reset(hard_reset),
    .power_ok_i(power_ok), .cause_i(pwr_cause), .irq_i(controller_irq_o),
    .chs_led_n_o(chs_led_n_o), .controller_reset_o(controller_reset_o)
  );

endmodule

`default_nettype wire

// File: design/bus_decoder.sv
`default_nettype none

module bus_decoder import bmc_pkg::*; (
  input  wire                   gclk40,
  input  wire                   hard_reset,
  input  wire bus_req_t         host_req_i,
  output bus_rsp_t              host_rsp_o,
  output logic [num_slaves-1:0] slave_sel_o,
  input  wire bus_rsp_t         slave_rsp_i [num_slaves],
  output logic                  memv_o
);

  logic unmapped;
  logic err_q;

  // one-hot select from the address, ranges never overlap
  always_comb begin
    slave_sel_o = '0;
    slave_sel_o[slv_sysconf] = (host_req_i.adr >= sysconf_base) &&
                               (host_req_i.adr <= sysconf_high);
    slave_sel_o[slv_pwrman]  = (host_req_i.adr >= pwrman_base) &&
                               (host_req_i.adr <= pwrman_high);
    slave_sel_o[slv_irqc]    = (host_req_i.adr >= irqc_base) &&
                               (host_req_i.adr <= irqc_high);
  end

  assign unmapped = ~|slave_sel_o;

  // err answers one cycle after stb, a single pulse per access
  always_ff @(posedge gclk40) begin
    if (!hard_reset) begin
      err_q <= 1'b0;
    end else begin
      err_q <= host_req_i.cyc && host_req_i.stb && unmapped && !err_q;
    end
  end

  assign memv_o = err_q;

  // the host holds adr until the response, so the select also steers the return path
  always_comb begin
    host_rsp_o     = '0;
    host_rsp_o.err = err_q;
    for (int i = 0; i < num_slaves; i++) begin
      if (slave_sel_o[i]) begin
        host_rsp_o.ack = slave_rsp_i[i].ack;
        host_rsp_o.dat = slave_rsp_i[i].dat;
      end
    end
  end

endmodule

`default_nettype wire

// File: design/button_debouncer.sv
`default_nettype none

module button_debouncer #(
  parameter int DEBOUNCE_CYCLES = 16
) (
  input  wire  gclk40,
  input  wire  hard_reset,
  input  wire  button_n_i,
  output logic pressed_o
);

  localparam int cnt_w = $clog2(DEBOUNCE_CYCLES + 1);

  logic [1:0]       sync_q;  // chassis switch is asynchronous to gclk40
  logic [cnt_w-1:0] cnt_q;

  always_ff @(posedge gclk40) begin
    if (!hard_reset) begin
      sync_q    <= 2'b00;
      cnt_q     <= '0;
      pressed_o <= 1'b0;
    end else begin
      sync_q <= {sync_q[0], ~button_n_i};
      if (sync_q[1] == pressed_o) begin
        cnt_q <= '0;  // no change pending, restart the count
      end else if (cnt_q == cnt_w'(DEBOUNCE_CYCLES - 1)) begin
        cnt_q     <= '0;
        pressed_o <= sync_q[1];
      end else begin
        cnt_q <= cnt_q + 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

// File: design/chassis_led.sv
`default_nettype none

module chassis_led import bmc_pkg::*; #(
  parameter int BLINK_BIT = 24
) (
  input  wire             gclk40,
  input  wire             hard_reset,
  input  wire             power_ok_i,
  input  wire pwr_cause_e cause_i,
  input  wire             irq_i,
  output logic [1:0]      chs_led_n_o,
  output logic            controller_reset_o
);

  logic [BLINK_BIT+2:0] cnt_q;
  logic                 power_led;
  logic                 action_led;

  always_ff @(posedge gclk40) begin
    if (!hard_reset) begin
      cnt_q <= '0;
    end else begin
      cnt_q <= cnt_q + 1'b1;
    end
  end

  // fast blink flags a supply fault, slow blink means no controller
  assign power_led  = power_ok_i ? 1'b1 :
                      (cause_i == cause_atx_fault) ? cnt_q[BLINK_BIT] : 1'b0;
  assign action_led = power_ok_i ? irq_i : cnt_q[BLINK_BIT+2];

  assign chs_led_n_o        = !hard_reset ? 2'b00 : ~{action_led, power_led};  // lamp test
  assign controller_reset_o = ~power_ok_i;

endmodule

`default_nettype wire

// File: design/irq_controller.sv
`default_nettype none

module irq_controller import bmc_pkg::*; (
  input  wire                gclk40,
  input  wire                hard_reset,
  input  wire                sel_i,
  input  wire bus_req_t      req_i,
  output bus_rsp_t           rsp_o,
  input  wire [num_irq-1:0]  irq_src_i,
  output logic               irq_o
);

  logic                  access;
  logic                  ack_q;
  logic [num_irq-1:0]    status_q;
  logic [num_irq-1:0]    mask_q;  // 1 enables the source
  logic [num_irq-1:0]    clr;
  logic [bus_data_w-1:0] rdata_q;

  assign access = sel_i && req_i.cyc && req_i.stb && !ack_q;
  assign clr    = (access && req_i.we && req_i.adr[3:0] == reg_irq_status) ?
                  req_i.dat[num_irq-1:0] : '0;

  always_ff @(posedge gclk40) begin
    if (!hard_reset) begin
      ack_q    <= 1'b0;
      status_q <= '0;
      mask_q   <= '1;
      irq_o    <= 1'b0;
    end else begin
      ack_q    <= access;
      status_q <= (status_q & ~clr) | irq_src_i;  // a new pulse beats a clear
      irq_o    <= |(status_q & mask_q);
      if (access && req_i.we && req_i.adr[3:0] == reg_irq_mask) begin
        mask_q <= req_i.dat[num_irq-1:0];
      end
    end
  end

  always_ff @(posedge gclk40) begin
    if (access) begin
      case (req_i.adr[3:0])
        reg_irq_status: rdata_q <= bus_data_w'(status_q);
        reg_irq_mask:   rdata_q <= bus_data_w'(mask_q);
        default:        rdata_q <= '0;
      endcase
    end
  end

  assign rsp_o = '{ack: ack_q, err: 1'b0, dat: rdata_q};

endmodule

`default_nettype wire

// File: design/power_sequencer.sv
`default_nettype none

module power_sequencer import bmc_pkg::*; #(
  parameter int POWER_UP_TIMEOUT = 1000,
  parameter int POWER_DOWN_WAIT  = 1000
) (
  input  wire           gclk40,
  input  wire           hard_reset,
  input  wire           sel_i,
  input  wire bus_req_t req_i,
  output bus_rsp_t      rsp_o,
  input  wire           button_i,
  input  wire           atx_pwr_ok_i,
  input  wire rail_pg_t rail_pg_i,
  output logic          atx_ps_on_n_o,
  output logic          atx_load_res_off_o,
  output rail_ctrl_t    rail_ctrl_o,
  output logic          power_ok_o,
  output pwr_cause_e    cause_o,
  output logic          pending_o,
  output logic          fault_o
);

  localparam int cnt_max = (POWER_UP_TIMEOUT > POWER_DOWN_WAIT) ?
                           POWER_UP_TIMEOUT : POWER_DOWN_WAIT;
  localparam int cnt_w   = $clog2(cnt_max + 1);

  pwr_state_e            state_q;
  pwr_cause_e            cause_q;
  logic [cnt_w-1:0]      cnt_q;
  logic                  pwr_req_q;
  logic                  button_q;
  logic                  access;
  logic                  ack_q;
  logic                  ctrl_wr;
  logic                  host_off;
  logic                  rails_en;
  logic [bus_data_w-1:0] rdata_q;

  assign access   = sel_i && req_i.cyc && req_i.stb && !ack_q;
  assign ctrl_wr  = access && req_i.we && req_i.adr[3:0] == reg_pwr_ctrl;
  assign host_off = ctrl_wr && !req_i.dat[0] && state_q != pwr_off;

  always_ff @(posedge gclk40) begin
    if (!hard_reset) begin
      state_q   <= pwr_off;
      cause_q   <= cause_none;
      cnt_q     <= '0;
      pwr_req_q <= 1'b0;
      button_q  <= 1'b0;
      ack_q     <= 1'b0;
      pending_o <= 1'b0;
      fault_o   <= 1'b0;
    end else begin
      ack_q     <= access;
      button_q  <= button_i;
      pending_o <= 1'b0;
      fault_o   <= 1'b0;
      cnt_q     <= cnt_q + 1'b1;  // only looked at in the timed states
      if (ctrl_wr) begin
        pwr_req_q <= req_i.dat[0];
      end
      if (host_off) begin
        state_q <= pwr_off;
        cause_q <= cause_host_off;
      end else begin
        case (state_q)
          pwr_off: begin
            if (ctrl_wr && req_i.dat[0]) begin
              state_q <= pwr_wait_atx;
              cnt_q   <= '0;
            end
          end
          pwr_wait_atx: begin
            if (atx_pwr_ok_i) begin
              state_q <= pwr_wait_rails;
            end else if (cnt_q == cnt_w'(POWER_UP_TIMEOUT - 1)) begin
              state_q   <= pwr_off;  // supply never came up
              cause_q   <= cause_atx_fault;
              pwr_req_q <= 1'b0;
              fault_o   <= 1'b1;
            end
          end
          pwr_wait_rails, pwr_on: begin
            if (!atx_pwr_ok_i) begin
              state_q   <= pwr_off;
              cause_q   <= cause_atx_fault;
              pwr_req_q <= 1'b0;
              fault_o   <= 1'b1;
            end else if (state_q == pwr_wait_rails && &rail_pg_i.mgt_pg) begin
              state_q <= pwr_on;
            end else if (state_q == pwr_on && button_i && !button_q) begin
              state_q   <= pwr_down_wait;  // give the controller time to shut down
              cnt_q     <= '0;
              pending_o <= 1'b1;
            end
          end
          pwr_down_wait: begin
            if (cnt_q == cnt_w'(POWER_DOWN_WAIT - 1)) begin
              state_q   <= pwr_off;
              cause_q   <= cause_button;
              pwr_req_q <= 1'b0;
            end
          end
          default: state_q <= pwr_off;
        endcase
      end
    end
  end

  always_ff @(posedge gclk40) begin
    if (access) begin
      case (req_i.adr[3:0])
        reg_pwr_ctrl:   rdata_q <= {15'b0, pwr_req_q};
        reg_pwr_status: rdata_q <= {7'b0, power_ok_o, 2'b0, cause_q, 1'b0, state_q};
        default:        rdata_q <= '0;
      endcase
    end
  end

  assign rsp_o = '{ack: ack_q, err: 1'b0, dat: rdata_q};

  // supply outputs follow the state
  assign rails_en = state_q inside {pwr_wait_rails, pwr_on, pwr_down_wait};
  assign atx_ps_on_n_o      = (state_q == pwr_off);
  assign atx_load_res_off_o = (state_q == pwr_on);
  assign power_ok_o         = (state_q == pwr_on);
  assign cause_o            = cause_q;

  always_comb begin
    rail_ctrl_o.track_2v5 = rails_en && rail_pg_i.aux_3v3_pg;  // 2v5 tracks the aux rail
    rail_ctrl_o.inhibit   = rails_en ? 5'b00000 : 5'b11111;
    rail_ctrl_o.mgt_en    = rails_en ? 3'b111 : 3'b000;
  end

endmodule

`default_nettype wire

// File: design/sys_config_regs.sv
`default_nettype none

module sys_config_regs import bmc_pkg::*; #(
  parameter logic [7:0]  BOARD_ID  = 8'h00,
  parameter logic [7:0]  REV_MAJOR = 8'h00,
  parameter logic [15:0] REV_MINOR = 16'h0000
) (
  input  wire           gclk40,
  input  wire           hard_reset,
  input  wire           sel_i,
  input  wire bus_req_t req_i,
  output bus_rsp_t      rsp_o,
  output logic [7:0]    sys_config_o
);

  logic                  access;
  logic                  ack_q;
  logic [bus_data_w-1:0] rdata_q;
  logic [7:0]            config_q;

  assign access = sel_i && req_i.cyc && req_i.stb && !ack_q;

  always_ff @(posedge gclk40) begin
    if (!hard_reset) begin
      ack_q    <= 1'b0;
      config_q <= 8'h00;
    end else begin
      ack_q <= access;
      if (access && req_i.we && req_i.adr[3:0] == reg_config) begin
        config_q <= req_i.dat[7:0];
      end
    end
  end

  always_ff @(posedge gclk40) begin
    if (access) begin
      case (req_i.adr[3:0])
        reg_board_id:  rdata_q <= {BOARD_ID, REV_MAJOR};
        reg_rev_minor: rdata_q <= REV_MINOR;
        reg_config:    rdata_q <= {8'h00, config_q};
        default:       rdata_q <= '0;  // unused offsets read as zero
      endcase
    end
  end

  assign rsp_o = '{ack: ack_q, err: 1'b0, dat: rdata_q};
  assign sys_config_o = config_q;

endmodule

`default_nettype wire

// File: list.f
design/bmc_pkg.sv
design/button_debouncer.sv
design/bus_decoder.sv
design/sys_config_regs.sv
design/power_sequencer.sv
design/irq_controller.sv
design/chassis_led.sv
design/bmc_top.sv
verif/bmc_tb.sv

// File: verif/bmc_tb.sv
`default_nettype none

module bmc_tb import bmc_pkg::*; ();
  timeunit 1ns;
  timeprecision 100ps;

  localparam logic [7:0]  board_id         = 8'h5a;
  localparam logic [7:0]  rev_major        = 8'h02;
  localparam logic [15:0] rev_minor        = 16'h0107;
  localparam int          debounce_cycles  = 8;
  localparam int          power_up_timeout = 50;
  localparam int          power_down_wait  = 20;
  localparam int          blink_bit        = 3;
  localparam int          bus_timeout      = 16;  // cycles before a bus access is abandoned

  logic       gclk40;
  logic       hard_reset;
  bus_req_t   host_req;
  bus_rsp_t   host_rsp;
  logic       chs_powerdown_n;
  logic       atx_pwr_ok;
  logic       atx_ps_on_n;
  logic       atx_load_res_off;
  rail_ctrl_t rail_ctrl;
  rail_pg_t   rail_pg;
  logic [7:0] sys_config;
  logic       controller_irq;
  logic       controller_reset;
  logic [1:0] chs_led_n;

  int check_errors;
  int timeout_errors;

  bmc_top #(
    .BOARD_ID(board_id), .REV_MAJOR(rev_major), .REV_MINOR(rev_minor),
    .DEBOUNCE_CYCLES(debounce_cycles), .POWER_UP_TIMEOUT(power_up_timeout),
    .POWER_DOWN_WAIT(power_down_wait), .BLINK_BIT(blink_bit)
  ) bmc_top_inst (
    .gclk40(gclk40), .hard_reset(hard_reset),
    .host_req_i(host_req), .host_rsp_o(host_rsp),
    .chs_powerdown_n_i(chs_powerdown_n), .atx_pwr_ok_i(atx_pwr_ok),
    .atx_ps_on_n_o(atx_ps_on_n), .atx_load_res_off_o(atx_load_res_off),
    .rail_ctrl_o(rail_ctrl), .rail_pg_i(rail_pg), .sys_config_o(sys_config),
    .controller_irq_o(controller_irq), .controller_reset_o(controller_reset),
    .chs_led_n_o(chs_led_n)
  );

  always #4 gclk40 = ~gclk40;

  task automatic report_mismatch(input string msg);
    $display("CHECK FAILED at %0t ns: %s", $time, msg);
    check_errors++;
  endtask

  task automatic report_timeout(input string msg);
    $display("Timeout at %0t ns: %s", $time, msg);
    timeout_errors++;
  endtask

  // one bus cycle, entered and left on a falling edge with stb low for a cycle after
  task automatic bus_access(input logic write, input logic [15:0] addr,
                            input logic [15:0] wdata, output logic [15:0] rdata,
                            output logic [1:0] ack_err);
    int waited;
    waited = 0;
    host_req = '{cyc: 1'b1, stb: 1'b1, we: write, adr: addr, dat: wdata};
    do begin
      @(negedge gclk40);
      waited++;
    end while (!host_rsp.ack && !host_rsp.err && waited < bus_timeout);
    rdata   = host_rsp.dat;
    ack_err = {host_rsp.ack, host_rsp.err};
    if (ack_err == 2'b00) begin
      report_timeout($sformatf("no ack or err for access to %h", addr));
    end else begin
      assert (waited == 1)
        else report_mismatch($sformatf("response to %h after %0d cycles", addr, waited));
    end
    host_req = '0;
    @(negedge gclk40);
  endtask

  task automatic bus_write(input logic [15:0] addr, input logic [15:0] wdata);
    logic [15:0] rdata;
    logic [1:0]  ack_err;
    bus_access(1'b1, addr, wdata, rdata, ack_err);
    assert (ack_err == 2'b10) else report_mismatch($sformatf("write to %h not acked", addr));
  endtask

  task automatic bus_read(input logic [15:0] addr, output logic [15:0] rdata);
    logic [1:0] ack_err;
    bus_access(1'b0, addr, 16'h0000, rdata, ack_err);
    assert (ack_err == 2'b10) else report_mismatch($sformatf("read of %h not acked", addr));
  endtask

  task automatic read_expect(input logic [15:0] addr, input logic [15:0] mask,
                             input logic [15:0] expected);
    logic [15:0] rdata;
    bus_read(addr, rdata);
    assert ((rdata & mask) == expected)
      else report_mismatch($sformatf("read %h got %h, expected %h", addr, rdata & mask,
                                     expected));
  endtask

  task automatic check_power_status(input pwr_state_e exp_state, input pwr_cause_e exp_cause);
    logic [15:0] expected;
    expected      = 16'h0000;
    expected[2:0] = exp_state;
    expected[5:4] = exp_cause;
    expected[8]   = (exp_state == pwr_on);  // power_ok
    read_expect(pwrman_base | reg_pwr_status, 16'h0137, expected);
  endtask

  task automatic wait_irq_level(input logic level, input int limit);
    int n;
    n = 0;
    while (controller_irq != level && n < limit) begin
      @(negedge gclk40);
      n++;
    end
    if (controller_irq != level) report_timeout($sformatf("irq never went to %b", level));
  endtask

  task automatic wait_supply_off(input int limit);
    int n;
    n = 0;
    while (!atx_ps_on_n && n < limit) begin
      @(negedge gclk40);
      n++;
    end
    if (!atx_ps_on_n) report_timeout("ATX supply was not switched off");
  endtask

  task automatic power_up_board();
    int atx_delay;
    int rail_delay;
    int n;
    atx_delay  = 1 + ($urandom % 20);  // stays well inside the power-up timeout
    rail_delay = 1 + ($urandom % 10);
    bus_write(pwrman_base | reg_pwr_ctrl, 16'h0001);
    assert (!atx_ps_on_n) else report_mismatch("ps_on_n not low after power request");
    assert (rail_ctrl.inhibit == 5'b11111) else report_mismatch("inhibits released early");
    repeat (atx_delay) @(negedge gclk40);
    atx_pwr_ok         = 1'b1;
    rail_pg.aux_3v3_pg = 1'b1;
    @(negedge gclk40);
    assert (rail_ctrl.inhibit == 5'b00000) else report_mismatch("inhibits still high");
    assert (rail_ctrl.mgt_en == 3'b111) else report_mismatch("mgt enables not raised");
    repeat (rail_delay) @(negedge gclk40);
    rail_pg.mgt_pg = 3'b111;
    n = 0;
    while (controller_reset && n < 10) begin
      @(negedge gclk40);
      n++;
    end
    if (controller_reset) report_timeout("power_ok never came up");
  endtask

  task automatic drop_supplies();
    atx_pwr_ok = 1'b0;
    rail_pg    = '0;
  endtask

  // bus protocol and lamp test, sampled on the rising edge
  assert property (@(posedge gclk40) disable iff (!hard_reset) !(host_rsp.ack && host_rsp.err))
    else report_mismatch("ack and err together");
  assert property (@(posedge gclk40) hard_reset || chs_led_n == 2'b00)
    else report_mismatch("LEDs not lit during reset");

  initial begin
    logic [15:0] rdata;
    logic [1:0]  ack_err;
    logic [7:0]  cfg;
    logic [1:0]  led_seen;
    gclk40          = 1'b0;
    hard_reset      = 1'b0;
    host_req        = '0;
    chs_powerdown_n = 1'b1;
    atx_pwr_ok      = 1'b0;
    rail_pg         = '0;
    check_errors    = 0;
    timeout_errors  = 0;
    void'($urandom(32'h2c44e0c2));

    @(negedge gclk40);
    assert (atx_ps_on_n && rail_ctrl.inhibit == 5'b11111 && !rail_ctrl.track_2v5 &&
            rail_ctrl.mgt_en == 3'b000) else report_mismatch("supply outputs not at reset");
    assert (!controller_irq && controller_reset) else report_mismatch("irq or reset wrong");
    assert (!host_rsp.ack && !host_rsp.err) else report_mismatch("bus response during reset");
    @(negedge gclk40);
    hard_reset = 1'b1;
    @(negedge gclk40);
    assert (atx_ps_on_n && controller_reset && chs_led_n[0])
      else report_mismatch("outputs not idle after reset");
    check_power_status(pwr_off, cause_none);
    read_expect(irqc_base | reg_irq_mask, 16'hffff, 16'h0007);

    // identity and config vector
    read_expect(sysconf_base | reg_board_id, 16'hffff, {board_id, rev_major});
    read_expect(sysconf_base | reg_rev_minor, 16'hffff, rev_minor);
    cfg = 8'($urandom);
    bus_write(sysconf_base | reg_config, {8'hff, cfg});
    assert (sys_config == cfg) else report_mismatch("sys_config_o does not show written value");
    read_expect(sysconf_base | reg_config, 16'hffff, {8'h00, cfg});

    // unmapped access and the memory violation interrupt
    bus_access(1'b1, 16'h0040, 16'h1234, rdata, ack_err);
    assert (ack_err == 2'b01) else report_mismatch("unmapped access not answered by err");
    read_expect(irqc_base | reg_irq_status, 16'h0007, 16'h0002);
    wait_irq_level(1'b1, 8);
    bus_write(irqc_base | reg_irq_mask, 16'h0005);
    wait_irq_level(1'b0, 8);
    repeat (4) @(negedge gclk40);
    assert (!controller_irq) else report_mismatch("masked irq still drives output");
    bus_write(irqc_base | reg_irq_status, 16'h0002);
    read_expect(irqc_base | reg_irq_status, 16'h0007, 16'h0000);
    bus_write(irqc_base | reg_irq_mask, 16'h0007);

    // normal power up, then host off
    power_up_board();
    check_power_status(pwr_on, cause_none);
    assert (!controller_reset && !chs_led_n[0] && atx_load_res_off)
      else report_mismatch("power_ok not shown on reset, LED or load resistor");
    assert (rail_ctrl.inhibit == 5'b00000) else report_mismatch("inhibits high in pwr_on");
    bus_write(pwrman_base | reg_pwr_ctrl, 16'h0000);
    check_power_status(pwr_off, cause_host_off);
    assert (atx_ps_on_n && rail_ctrl.inhibit == 5'b11111) else report_mismatch("supply not off");
    drop_supplies();

    // ATX never comes up
    bus_write(pwrman_base | reg_pwr_ctrl, 16'h0001);
    wait_supply_off(power_up_timeout + 10);
    check_power_status(pwr_off, cause_atx_fault);
    read_expect(irqc_base | reg_irq_status, 16'h0004, 16'h0004);
    led_seen = 2'b00;
    repeat (4 << blink_bit) begin  // two full fast blink periods
      @(negedge gclk40);
      led_seen[chs_led_n[0]] = 1'b1;
    end
    assert (led_seen == 2'b11) else report_mismatch("power LED does not blink on fault");
    bus_write(irqc_base | reg_irq_status, 16'h0007);

    // chassis button, short glitch first
    power_up_board();
    chs_powerdown_n = 1'b0;
    repeat (debounce_cycles - 1) @(negedge gclk40);
    chs_powerdown_n = 1'b1;
    repeat (debounce_cycles * 3) @(negedge gclk40);
    read_expect(irqc_base | reg_irq_status, 16'h0001, 16'h0000);
    assert (!controller_reset) else report_mismatch("short button pulse left pwr_on");
    chs_powerdown_n = 1'b0;
    repeat (debounce_cycles * 2) @(negedge gclk40);
    chs_powerdown_n = 1'b1;
    read_expect(irqc_base | reg_irq_status, 16'h0001, 16'h0001);
    wait_supply_off(power_down_wait + 20);
    check_power_status(pwr_off, cause_button);
    drop_supplies();

    repeat (2) @(negedge gclk40);
    $display("check errors: %0d, timeouts: %0d", check_errors, timeout_errors);
    if (check_errors == 0 && timeout_errors == 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

endmodule

`default_nettype wire
